// File: lpif_pkg.sv
// LPIF adapter shared types
// Lane widths, flit fields and link word

package lpif_pkg;

  ////////////////////////////////////////
  // Lane format
  ////////////////////////////////////////

  // Width of one PHY lane
  localparam int lane_w     = 80;
  // Lanes per link
  localparam int lane_n     = 4;
  // Flit payload bits carried by each lane
  localparam int payload_w  = 72;
  // Link word, four payloads side by side
  localparam int link_w     = lane_n * payload_w;
  // Marker bits in each lane
  localparam int marker_w   = 2;
  // Top lane bits left over, sent as zero
  localparam int reserved_w = lane_w - marker_w - 1 - payload_w;

  // Real flit content, spare bits excluded
  localparam int flit_w     = 282;
  // Padding so the flit fills the link word
  localparam int spare_w    = link_w - flit_w;

  ////////////////////////////////////////
  // Debug status word
  ////////////////////////////////////////

  localparam int dbg_w             = 32;
  localparam int dbg_tx_online_bit = 19;
  localparam int dbg_rx_online_bit = 18;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Flit fields, valid in the lowest bits
  typedef struct packed {
    logic [spare_w-1:0] spare;
    logic [7:0]         state;
    logic [3:0]         protid;
    logic [255:0]       data;
    logic [1:0]         dvalid;
    logic [7:0]         crc;
    logic [1:0]         crc_valid;
    logic [1:0]         valid;
  } lpif_flit_s;

  // One PHY lane word, top bit first
  typedef struct packed {
    logic [reserved_w-1:0] reserved;
    logic [marker_w-1:0]   marker;
    logic                  strobe;
    logic [payload_w-1:0]  payload;
  } lane_s;

  // Link word seen as flit fields or as lane payloads
  // Lane 0 payload sits in the lowest bits
  typedef union packed {
    lpif_flit_s                            fields;
    logic [lane_n-1:0][payload_w-1:0]      lanes;
  } link_word_u;

endpackage

// File: lpif_auto_sync.sv
// Online sequencing
// Delayed online levels, marker and strobe

`timescale 1ns/10ps

module lpif_auto_sync (
  input  logic                          clk_wr,
  input  logic                          arst_n,
  input  logic                          tx_online,
  input  logic                          rx_online,
  input  logic [15:0]                   delay_x_value,
  input  logic [15:0]                   delay_y_value,
  input  logic [15:0]                   delay_z_value,
  input  logic [lpif_pkg::marker_w-1:0] tx_mrk_userbit,
  input  logic                          tx_stb_userbit,
  output logic                          tx_online_delay,
  output logic                          rx_online_delay,
  output logic [lpif_pkg::marker_w-1:0] tx_marker,
  output logic                          tx_strobe
);

  import lpif_pkg::*;

  // Cycle counters, each held at zero while its level is low
  logic [15:0] tx_cnt;
  logic [15:0] rx_cnt;
  logic [15:0] stb_cnt;
  logic        stb_timed;

  // Count up to the programmed limit, then hold
  function automatic logic [15:0] cnt_step(input logic [15:0] cnt,
                                           input logic [15:0] lim);
    cnt_step = (cnt < lim) ? cnt + 16'd1 : cnt;
  endfunction

  ////////////////////////////////////////
  // Online delays
  ////////////////////////////////////////

  // TX side, timed by delay_y
  // Level rises once the count has reached the limit
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_cnt          <= '0;
      tx_online_delay <= 1'b0;
    end else if (!tx_online) begin
      // Drop at once, restart the count
      tx_cnt          <= '0;
      tx_online_delay <= 1'b0;
    end else begin
      tx_cnt          <= cnt_step(tx_cnt, delay_y_value);
      tx_online_delay <= (tx_cnt >= delay_y_value);
    end
  end

  // RX side, timed by delay_x
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (!rx_online) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else begin
      rx_cnt          <= cnt_step(rx_cnt, delay_x_value);
      rx_online_delay <= (rx_cnt >= delay_x_value);
    end
  end

  ////////////////////////////////////////
  // Marker and strobe
  ////////////////////////////////////////

  // Strobe timer starts when TX goes online
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      stb_cnt <= '0;
    end else if (!tx_online_delay) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= cnt_step(stb_cnt, delay_z_value);
    end
  end

  // Persistent once reached
  assign stb_timed = tx_online_delay && (stb_cnt >= delay_z_value);

  // User bit can force the strobe early
  assign tx_strobe = stb_timed || (tx_online_delay && tx_stb_userbit);

  // Persistent marker, only while TX is online
  assign tx_marker = tx_online_delay ? tx_mrk_userbit : {marker_w{1'b0}};

endmodule

// File: lpif_flit_pack.sv
// Flit packing
// Downstream fields to link word and back

`timescale 1ns/10ps

module lpif_flit_pack (
  input  logic                 clk_wr,
  input  logic                 arst_n,
  input  lpif_pkg::lpif_flit_s dstrm,
  output lpif_pkg::link_word_u tx_link,
  input  lpif_pkg::link_word_u rx_link,
  input  logic                 rx_online_delay,
  output lpif_pkg::lpif_flit_s ustrm
);

  import lpif_pkg::*;

  ////////////////////////////////////////
  // Downstream pack
  ////////////////////////////////////////

  // Plain field copy into the fields view
  // Spare bits forced low, lanes see a clean top slice
  always_comb begin
    tx_link              = '0;
    tx_link.fields       = dstrm;
    tx_link.fields.spare = {spare_w{1'b0}};
  end

  ////////////////////////////////////////
  // Upstream unpack
  ////////////////////////////////////////

  // One register stage from the link word
  // Offline receive clears the whole flit
  // So nothing stale with a valid bit gets out
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      ustrm <= '0;
    end else if (!rx_online_delay) begin
      ustrm <= '0;
    end else begin
      // Fields view of the received word
      ustrm.state     <= rx_link.fields.state;
      ustrm.protid    <= rx_link.fields.protid;
      ustrm.data      <= rx_link.fields.data;
      ustrm.dvalid    <= rx_link.fields.dvalid;
      ustrm.crc       <= rx_link.fields.crc;
      ustrm.crc_valid <= rx_link.fields.crc_valid;
      ustrm.valid     <= rx_link.fields.valid;
      // Spare ignored on receive
      ustrm.spare     <= {spare_w{1'b0}};
    end
  end

endmodule

// File: lpif_lane_map.sv
// Lane mapping
// Link word to four PHY lanes and back

`timescale 1ns/10ps

module lpif_lane_map (
  input  logic                                       clk_wr,
  input  logic                                       arst_n,
  input  lpif_pkg::link_word_u                       tx_link,
  input  logic                                       tx_online_delay,
  input  logic [lpif_pkg::marker_w-1:0]              tx_marker,
  input  logic                                       tx_strobe,
  output lpif_pkg::lane_s [lpif_pkg::lane_n-1:0]     tx_phy,
  input  lpif_pkg::lane_s [lpif_pkg::lane_n-1:0]     rx_phy,
  output lpif_pkg::link_word_u                       rx_link
);

  import lpif_pkg::*;

  // Next lane words before the TX register
  lane_s [lane_n-1:0] tx_lane_next;

  ////////////////////////////////////////
  // TX lane build
  ////////////////////////////////////////

  // Each lane takes its own payload slice
  // Marker and strobe are shared by all lanes
  always_comb begin
    for (int i = 0; i < lane_n; i++) begin
      tx_lane_next[i].reserved = {reserved_w{1'b0}};
      tx_lane_next[i].marker   = tx_marker;
      tx_lane_next[i].strobe   = tx_strobe;
      tx_lane_next[i].payload  = tx_link.lanes[i];
    end
  end

  ////////////////////////////////////////
  // TX register
  ////////////////////////////////////////

  // Single stage towards the PHY
  // All lanes idle at zero while TX is offline
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy <= '0;
    end else if (!tx_online_delay) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_lane_next;
    end
  end

  ////////////////////////////////////////
  // RX gather
  ////////////////////////////////////////

  // Payloads only, back into the lanes view
  // Marker, strobe and reserved bits dropped here
  // No gating, the packer handles offline receive
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < lane_n; i++) begin
      rx_link.lanes[i] <= rx_phy[i].payload;
    end
  end

endmodule

// File: lpif_master_top.sv
// LPIF master adapter top
// Sequencing, packing and lane mapping

`timescale 1ns/10ps

module lpif_master_top (
  input  logic                                   clk_wr,
  input  logic                                   arst_n,

  // Online control
  input  logic                                   tx_online,
  input  logic                                   rx_online,

  // Marker, strobe and delay setup
  input  logic [lpif_pkg::marker_w-1:0]          tx_mrk_userbit,
  input  logic                                   tx_stb_userbit,
  input  logic [15:0]                            delay_x_value,
  input  logic [15:0]                            delay_y_value,
  input  logic [15:0]                            delay_z_value,

  // User flit channels
  input  lpif_pkg::lpif_flit_s                   dstrm,
  output lpif_pkg::lpif_flit_s                   ustrm,

  // PHY lanes
  output lpif_pkg::lane_s [lpif_pkg::lane_n-1:0] tx_phy,
  input  lpif_pkg::lane_s [lpif_pkg::lane_n-1:0] rx_phy,

  // Status
  output logic [lpif_pkg::dbg_w-1:0]             debug_status
);

  import lpif_pkg::*;

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  link_word_u          tx_link;
  link_word_u          rx_link;
  logic                tx_online_delay;
  logic                rx_online_delay;
  logic [marker_w-1:0] tx_marker;
  logic                tx_strobe;

  // Online delays, marker and strobe
  lpif_auto_sync lpif_auto_sync_inst (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_marker       (tx_marker),
    .tx_strobe       (tx_strobe)
  );

  // No FIFO or credits, flits go straight to the link word
  lpif_flit_pack lpif_flit_pack_inst (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .dstrm           (dstrm),
    .tx_link         (tx_link),
    .rx_link         (rx_link),
    .rx_online_delay (rx_online_delay),
    .ustrm           (ustrm)
  );

  // Link word across the four lanes
  lpif_lane_map lpif_lane_map_inst (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_link         (tx_link),
    .tx_online_delay (tx_online_delay),
    .tx_marker       (tx_marker),
    .tx_strobe       (tx_strobe),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .rx_link         (rx_link)
  );

  // Debug word, only the two online levels
  always_comb begin
    debug_status                    = '0;
    debug_status[dbg_tx_online_bit] = tx_online_delay;
    debug_status[dbg_rx_online_bit] = rx_online_delay;
  end

endmodule

// File: lpif_checker.sv
// Bound assertions
// Reset, gating and lane format

`timescale 1ns/10ps

module lpif_checker (
  input logic                                   clk_wr,
  input logic                                   arst_n,
  input logic                                   tx_online_delay,
  input lpif_pkg::lane_s [lpif_pkg::lane_n-1:0] tx_phy,
  input lpif_pkg::lpif_flit_s                   ustrm,
  input logic [lpif_pkg::dbg_w-1:0]             debug_status
);

  import lpif_pkg::*;

  // All outputs quiet in reset
  a_reset_zero: assert property (@(posedge clk_wr)
    !arst_n |-> (tx_phy == '0 && ustrm == '0 && debug_status == '0))
    else $error("outputs not zero during reset");

  // Lanes follow the online level of the previous edge
  a_tx_gate: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !$past(tx_online_delay) |-> tx_phy == '0)
    else $error("tx_phy active while transmit offline");

  // Reserved lane bits
  a_reserved: assert property (@(posedge clk_wr)
    (tx_phy[0].reserved | tx_phy[1].reserved |
     tx_phy[2].reserved | tx_phy[3].reserved) == '0)
    else $error("reserved lane bits set");

  // No valid upstream while receive offline
  a_rx_gate: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !$past(debug_status[dbg_rx_online_bit]) |-> ustrm.valid == '0)
    else $error("ustrm valid while receive offline");

endmodule

bind lpif_master_top lpif_checker lpif_checker_inst (
  .clk_wr          (clk_wr),
  .arst_n          (arst_n),
  .tx_online_delay (tx_online_delay),
  .tx_phy          (tx_phy),
  .ustrm           (ustrm),
  .debug_status    (debug_status)
);

// File: lpif_monitor.sv
// LPIF master monitor
// Reference model and output compare

`timescale 1ns/10ps

module lpif_monitor (
  input  logic                                   clk_wr,
  input  logic                                   arst_n,
  input  logic                                   tx_online,
  input  logic                                   rx_online,
  input  logic [15:0]                            delay_x_value,
  input  logic [15:0]                            delay_y_value,
  input  logic [15:0]                            delay_z_value,
  input  logic [lpif_pkg::marker_w-1:0]          tx_mrk_userbit,
  input  logic                                   tx_stb_userbit,
  input  lpif_pkg::lpif_flit_s                   dstrm,
  input  lpif_pkg::lpif_flit_s                   ustrm,
  input  lpif_pkg::lane_s [lpif_pkg::lane_n-1:0] tx_phy,
  input  logic [lpif_pkg::dbg_w-1:0]             debug_status,
  output int                                     err_count,
  output int                                     check_count
);

  import lpif_pkg::*;

  typedef lane_s [lane_n-1:0] lanes_t;

  // Expected outputs for the next compare
  lanes_t           exp_tx   = '0;
  lpif_flit_s       exp_u    = '0;
  logic [dbg_w-1:0] exp_dbg  = '0;
  // Model of rx_link, one stage behind tx_phy
  lanes_t           rx_model = '0;

  // Online and strobe models
  logic m_ton  = 1'b0;
  logic m_ron  = 1'b0;
  int   tx_cnt = 0;
  int   rx_cnt = 0;
  int   z_cnt  = 0;
  int   errs   = 0;
  int   checks = 0;

  assign err_count   = errs;
  assign check_count = checks;

  ////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////

  // Flit spread over the lanes, spare bits cleared
  function automatic lanes_t lanes_of(input lpif_flit_s f,
                                      input logic [marker_w-1:0] mrk,
                                      input logic stb);
    logic [link_w-1:0] bits;
    bits = f;
    bits[link_w-1 -: spare_w] = '0;
    for (int i = 0; i < lane_n; i++) begin
      lanes_of[i].reserved = '0;
      lanes_of[i].marker   = mrk;
      lanes_of[i].strobe   = stb;
      lanes_of[i].payload  = bits[i*payload_w +: payload_w];
    end
  endfunction

  // Lane payloads gathered back into a flit
  function automatic lpif_flit_s flit_of(input lanes_t l);
    logic [link_w-1:0] bits;
    for (int i = 0; i < lane_n; i++) begin
      bits[i*payload_w +: payload_w] = l[i].payload;
    end
    flit_of       = bits;
    flit_of.spare = '0;
  endfunction

  ////////////////////////////////////////
  // Compare and model step
  ////////////////////////////////////////

  always @(posedge clk_wr) begin
    logic stb;
    // Outputs here still hold the values of the previous edge
    for (int i = 0; i < lane_n; i++) begin
      checks++;
      if (tx_phy[i] !== exp_tx[i]) begin
        errs++;
        $display("mismatch at %0t: tx_phy lane %0d is %h, expected %h",
                 $time, i, tx_phy[i], exp_tx[i]);
      end
    end
    checks++;
    if (ustrm !== exp_u) begin
      errs++;
      $display("mismatch at %0t: ustrm is %h, expected %h", $time, ustrm, exp_u);
    end
    checks++;
    if (debug_status !== exp_dbg) begin
      errs++;
      $display("mismatch at %0t: debug_status is %h, expected %h",
               $time, debug_status, exp_dbg);
    end

    // rx_link samples tx_phy even in reset
    exp_u    = (arst_n && m_ron) ? flit_of(rx_model) : '0;
    rx_model = exp_tx;

    if (!arst_n) begin
      exp_tx  = '0;
      exp_dbg = '0;
      m_ton   = 1'b0;
      m_ron   = 1'b0;
      tx_cnt  = 0;
      rx_cnt  = 0;
      z_cnt   = 0;
    end else begin
      // Timed strobe or forced by the user bit
      stb    = m_ton && ((z_cnt >= int'(delay_z_value)) || tx_stb_userbit);
      exp_tx = m_ton ? lanes_of(dstrm, tx_mrk_userbit, stb) : '0;
      if (!m_ton) begin
        z_cnt = 0;
      end else if (z_cnt < int'(delay_z_value)) begin
        z_cnt++;
      end
      // Level rises delay plus one edges after the input
      if (!tx_online) begin
        tx_cnt = 0;
      end else if (tx_cnt <= int'(delay_y_value)) begin
        tx_cnt++;
      end
      m_ton = tx_online && (tx_cnt >= int'(delay_y_value) + 1);
      if (!rx_online) begin
        rx_cnt = 0;
      end else if (rx_cnt <= int'(delay_x_value)) begin
        rx_cnt++;
      end
      m_ron = rx_online && (rx_cnt >= int'(delay_x_value) + 1);
      exp_dbg                    = '0;
      exp_dbg[dbg_tx_online_bit] = m_ton;
      exp_dbg[dbg_rx_online_bit] = m_ron;
    end
  end

endmodule

// File: lpif_tb.sv
// LPIF master testbench
// Loopback with LFSR flits

`timescale 1ns/10ps

module lpif_tb;

  import lpif_pkg::*;

  logic                      clk_wr = 1'b0;
  logic                      arst_n;
  logic                      tx_online;
  logic                      rx_online;
  logic [marker_w-1:0]       tx_mrk_userbit;
  logic                      tx_stb_userbit;
  logic [15:0]               delay_x_value;
  logic [15:0]               delay_y_value;
  logic [15:0]               delay_z_value;
  lpif_flit_s                dstrm;
  lpif_flit_s                ustrm;
  lane_s [lane_n-1:0]        phy_loop;
  logic [dbg_w-1:0]          debug_status;
  int                        err_count;
  int                        check_count;
  int                        timeouts = 0;
  int                        base;
  logic [31:0]               lfsr_state = 32'd42;

  // 4 ns period
  always #2 clk_wr = ~clk_wr;

  // tx_phy loops straight back into rx_phy
  lpif_master_top lpif_master_top_inst (
    .clk_wr (clk_wr), .arst_n (arst_n),
    .tx_online (tx_online), .rx_online (rx_online),
    .tx_mrk_userbit (tx_mrk_userbit), .tx_stb_userbit (tx_stb_userbit),
    .delay_x_value (delay_x_value), .delay_y_value (delay_y_value),
    .delay_z_value (delay_z_value),
    .dstrm (dstrm), .ustrm (ustrm),
    .tx_phy (phy_loop), .rx_phy (phy_loop),
    .debug_status (debug_status)
  );

  lpif_monitor lpif_monitor_inst (
    .clk_wr (clk_wr), .arst_n (arst_n),
    .tx_online (tx_online), .rx_online (rx_online),
    .delay_x_value (delay_x_value), .delay_y_value (delay_y_value),
    .delay_z_value (delay_z_value),
    .tx_mrk_userbit (tx_mrk_userbit), .tx_stb_userbit (tx_stb_userbit),
    .dstrm (dstrm), .ustrm (ustrm), .tx_phy (phy_loop),
    .debug_status (debug_status),
    .err_count (err_count), .check_count (check_count)
  );

  // Galois LFSR step for one bit
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    galois_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // Edges from online input to delayed level
  function automatic int expected_online_delay(input logic [15:0] d);
    expected_online_delay = int'(d) + 1;
  endfunction

  task automatic next_flit(output lpif_flit_s f);
    f = '0;
    for (int i = 0; i < flit_w; i++) begin
      lfsr_state = galois_step(lfsr_state);
      f[i]       = lfsr_state[0];
    end
  endtask

  // One new flit on every falling edge
  task automatic send_flits(input int n);
    lpif_flit_s f;
    repeat (n) begin
      @(negedge clk_wr);
      next_flit(f);
      dstrm = f;
    end
  endtask

  // Poll a debug bit until it reaches the level
  task automatic wait_debug(input int pos, input logic level, input int limit);
    int n;
    n = 0;
    while (debug_status[pos] !== level && n < limit) begin
      @(negedge clk_wr);
      n++;
    end
    if (debug_status[pos] !== level) begin
      timeouts++;
      $display("timeout: debug bit %0d did not reach %0b within %0d cycles",
               pos, level, limit);
    end
  endtask

  task automatic report_test(input string name, input int start);
    $display("test %s done: %0d errors", name, err_count - start);
  endtask

  initial begin
    arst_n         = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    tx_mrk_userbit = 2'b10;
    tx_stb_userbit = 1'b0;
    delay_x_value  = 16'd9;
    delay_y_value  = 16'd5;
    delay_z_value  = 16'd3;
    dstrm          = '0;

    // Reset and offline state
    base = err_count;
    repeat (10) @(negedge clk_wr);
    arst_n = 1'b1;
    send_flits(20);
    report_test("reset_offline", base);

    // Online delay rise and fall
    base = err_count;
    tx_online = 1'b1;
    wait_debug(dbg_tx_online_bit, 1'b1, expected_online_delay(delay_y_value) + 4);
    rx_online = 1'b1;
    wait_debug(dbg_rx_online_bit, 1'b1, expected_online_delay(delay_x_value) + 4);
    @(negedge clk_wr);
    tx_online = 1'b0;
    rx_online = 1'b0;
    wait_debug(dbg_tx_online_bit, 1'b0, 2);
    wait_debug(dbg_rx_online_bit, 1'b0, 2);
    tx_online = 1'b1;
    rx_online = 1'b1;
    wait_debug(dbg_rx_online_bit, 1'b1, expected_online_delay(delay_x_value) + 4);
    report_test("online_delay", base);

    // Lane format with timed then forced strobe
    base = err_count;
    send_flits(30);
    @(negedge clk_wr);
    tx_online      = 1'b0;
    tx_stb_userbit = 1'b1;
    tx_mrk_userbit = 2'b01;
    @(negedge clk_wr);
    tx_online = 1'b1;
    wait_debug(dbg_tx_online_bit, 1'b1, expected_online_delay(delay_y_value) + 4);
    send_flits(10);
    tx_stb_userbit = 1'b0;
    send_flits(10);
    report_test("lane_format", base);

    // Loopback integrity
    base = err_count;
    send_flits(200);
    report_test("loopback", base);

    // Offline drop mid stream
    base = err_count;
    send_flits(20);
    rx_online = 1'b0;
    send_flits(5);
    rx_online = 1'b1;
    wait_debug(dbg_rx_online_bit, 1'b1, expected_online_delay(delay_x_value) + 4);
    send_flits(30);
    repeat (6) @(negedge clk_wr);
    report_test("offline_drop", base);

    $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeouts);
    if (err_count == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
lpif_pkg.sv
lpif_auto_sync.sv
lpif_flit_pack.sv
lpif_lane_map.sv
lpif_master_top.sv
lpif_checker.sv
lpif_monitor.sv
lpif_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -sv
TOP       ?= lpif_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -sv --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
